// ==== verilog/rv_core_cfg.svh ====
`ifndef RV_CORE_CFG_SVH
`define RV_CORE_CFG_SVH

// data path and address width
`define RV_XLEN 32

// architectural register file size
`define RV_REG_COUNT 32
`define RV_REG_IDX_W 5

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// sequential fetch step, one 32-bit instruction
`define RV_PC_STEP 32'd4

`endif

// ==== verilog/rv_core_pkg.sv ====
`include "rv_core_cfg.svh"

package rv_core_pkg;

  // major opcodes handled by this core
  typedef enum logic [6:0] {
    OP_LUI    = 7'b01_101_11,
    OP_IMM    = 7'b00_100_11,
    OP_REG    = 7'b01_100_11,
    OP_BRANCH = 7'b11_000_11,
    OP_SYSTEM = 7'b11_100_11
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    BR_NONE,
    BR_EQ,
    BR_NE,
    BR_LT,
    BR_GE,
    BR_LTU,
    BR_GEU
  } branch_e;

  typedef struct packed {
    logic [`RV_REG_IDX_W-1:0] rs1;
    logic [`RV_REG_IDX_W-1:0] rs2;
    logic [`RV_REG_IDX_W-1:0] rd;
    alu_op_e                  alu_op;
    logic                     use_imm;
    logic [`RV_XLEN-1:0]      imm;
    logic                     reg_we;
    branch_e                  branch;
    logic [`RV_XLEN-1:0]      br_offset;
    logic                     is_ecall;
  } decoded_t;

  // all three compare operand a against operand b
  typedef struct packed {
    logic zero;
    logic lt_signed;
    logic lt_unsigned;
  } alu_flags_t;

  typedef struct packed {
    logic                     valid;
    logic [`RV_REG_IDX_W-1:0] rd;
    logic [`RV_XLEN-1:0]      data;
  } retire_t;

endpackage

// ==== verilog/rv_decode.sv ====
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_decode (
  input  logic [`RV_XLEN-1:0] i_insn,
  output rv_core_pkg::decoded_t o_dec
);

  rv_core_pkg::opcode_e opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  logic [`RV_XLEN-1:0]  imm_i;
  logic [`RV_XLEN-1:0]  imm_b;
  logic [`RV_XLEN-1:0]  imm_u;

  // shared funct3 mapping for register-immediate and register-register ops
  function automatic rv_core_pkg::alu_op_e alu_from_funct3(input logic [2:0] f3,
                                                           input logic alt);
    rv_core_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
      3'b001:  op = rv_core_pkg::ALU_SLL;
      3'b010:  op = rv_core_pkg::ALU_SLT;
      3'b011:  op = rv_core_pkg::ALU_SLTU;
      3'b100:  op = rv_core_pkg::ALU_XOR;
      3'b101:  op = alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
      3'b110:  op = rv_core_pkg::ALU_OR;
      default: op = rv_core_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = rv_core_pkg::opcode_e'(i_insn[6:0]);
  assign funct3 = i_insn[14:12];
  assign funct7 = i_insn[31:25];

  // sltiu also takes the sign-extended immediate, compared unsigned
  assign imm_i = {{(`RV_XLEN-12){i_insn[31]}}, i_insn[31:20]};
  assign imm_b = {{(`RV_XLEN-13){i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25],
                  i_insn[11:8], 1'b0};
  assign imm_u = {i_insn[31:12], 12'b0};

  always_comb begin
    o_dec           = '0;
    o_dec.rs1       = i_insn[19:15];
    o_dec.rs2       = i_insn[24:20];
    o_dec.rd        = i_insn[11:7];
    o_dec.alu_op    = rv_core_pkg::ALU_ADD;
    o_dec.branch    = rv_core_pkg::BR_NONE;
    o_dec.imm       = imm_i;
    o_dec.br_offset = imm_b;

    case (opcode)
      rv_core_pkg::OP_LUI: begin
        o_dec.alu_op  = rv_core_pkg::ALU_PASS_B;
        o_dec.use_imm = 1'b1;
        o_dec.imm     = imm_u;
        o_dec.reg_we  = 1'b1;
      end
      rv_core_pkg::OP_IMM: begin
        o_dec.use_imm = 1'b1;
        o_dec.alu_op  = alu_from_funct3(funct3, (funct3 == 3'b101) && funct7[5]);
        // shift encodings only allow 0x00 or 0x20 in the upper bits
        if (funct3 == 3'b001) begin
          o_dec.reg_we = (funct7 == 7'h00);
        end else if (funct3 == 3'b101) begin
          o_dec.reg_we = (funct7 == 7'h00) || (funct7 == 7'h20);
        end else begin
          o_dec.reg_we = 1'b1;
        end
      end
      rv_core_pkg::OP_REG: begin
        o_dec.alu_op = alu_from_funct3(funct3, funct7[5]);
        o_dec.reg_we = (funct7 == 7'h00) ||
                       ((funct7 == 7'h20) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
      end
      rv_core_pkg::OP_BRANCH: begin
        // use_imm stays low so the alu compares rs1 with rs2
        case (funct3)
          3'b000:  o_dec.branch = rv_core_pkg::BR_EQ;
          3'b001:  o_dec.branch = rv_core_pkg::BR_NE;
          3'b100:  o_dec.branch = rv_core_pkg::BR_LT;
          3'b101:  o_dec.branch = rv_core_pkg::BR_GE;
          3'b110:  o_dec.branch = rv_core_pkg::BR_LTU;
          3'b111:  o_dec.branch = rv_core_pkg::BR_GEU;
          default: o_dec.branch = rv_core_pkg::BR_NONE;
        endcase
      end
      rv_core_pkg::OP_SYSTEM: begin
        o_dec.is_ecall = (i_insn[31:7] == '0);
      end
      default: begin
        // unknown opcode, falls through as a plain pc+4
      end
    endcase
  end

  // a branch never writes the register file
  always_comb begin
    assert (!(o_dec.reg_we && (o_dec.branch != rv_core_pkg::BR_NONE)));
  end

endmodule

// ==== verilog/rv_alu.sv ====
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_alu (
  input  rv_core_pkg::decoded_t   i_dec,
  input  logic [`RV_XLEN-1:0]     i_rs1_data,
  input  logic [`RV_XLEN-1:0]     i_rs2_data,
  output logic [`RV_XLEN-1:0]     o_result,
  output rv_core_pkg::alu_flags_t o_flags
);

  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] diff;
  logic [4:0]          shamt;
  logic                overflow;

  assign op_a  = i_rs1_data;
  assign op_b  = i_dec.use_imm ? i_dec.imm : i_rs2_data;
  assign shamt = op_b[4:0];
  assign diff  = op_a - op_b;

  // signed overflow of a - b, corrects the sign bit for slt and blt
  assign overflow = (op_a[`RV_XLEN-1] != op_b[`RV_XLEN-1]) &&
                    (diff[`RV_XLEN-1] != op_a[`RV_XLEN-1]);

  assign o_flags.zero        = (diff == '0);
  assign o_flags.lt_signed   = diff[`RV_XLEN-1] ^ overflow;
  assign o_flags.lt_unsigned = (op_a < op_b);

  always_comb begin
    case (i_dec.alu_op)
      rv_core_pkg::ALU_ADD:    o_result = op_a + op_b;
      rv_core_pkg::ALU_SUB:    o_result = diff;
      rv_core_pkg::ALU_SLL:    o_result = op_a << shamt;
      rv_core_pkg::ALU_SLT:    o_result = {{(`RV_XLEN-1){1'b0}}, o_flags.lt_signed};
      rv_core_pkg::ALU_SLTU:   o_result = {{(`RV_XLEN-1){1'b0}}, o_flags.lt_unsigned};
      rv_core_pkg::ALU_XOR:    o_result = op_a ^ op_b;
      rv_core_pkg::ALU_SRL:    o_result = op_a >> shamt;
      rv_core_pkg::ALU_SRA:    o_result = $unsigned($signed(op_a) >>> shamt);
      rv_core_pkg::ALU_OR:     o_result = op_a | op_b;
      rv_core_pkg::ALU_AND:    o_result = op_a & op_b;
      rv_core_pkg::ALU_PASS_B: o_result = op_b;
      default:                 o_result = op_a + op_b;
    endcase
  end

endmodule

// ==== verilog/rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_regfile (
  input  logic                  clk,
  input  logic                  rst,
  input  rv_core_pkg::decoded_t i_dec,
  input  logic                  i_commit,
  input  logic [`RV_XLEN-1:0]   i_wr_data,
  output logic [`RV_XLEN-1:0]   o_rs1_data,
  output logic [`RV_XLEN-1:0]   o_rs2_data,
  output rv_core_pkg::retire_t  o_retire
);

  logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];
  logic                wr_en;

  // x0 is never written, so it keeps its reset value of zero
  assign wr_en = i_commit && i_dec.reg_we && (i_dec.rd != '0);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[i_dec.rd] <= i_wr_data;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_retire <= '0;
    end else begin
      o_retire.valid <= wr_en;
      o_retire.rd    <= i_dec.rd;
      o_retire.data  <= i_wr_data;
    end
  end

  assign o_rs1_data = regs[i_dec.rs1];
  assign o_rs2_data = regs[i_dec.rs2];

  // a reported write never targets x0
  assert property (@(posedge clk) disable iff (rst)
    o_retire.valid |-> (o_retire.rd != '0));

endmodule

// ==== verilog/rv_fetch.sv ====
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_fetch (
  input  logic                    clk,
  input  logic                    rst,
  input  rv_core_pkg::decoded_t   i_dec,
  input  rv_core_pkg::alu_flags_t i_flags,
  output logic [`RV_XLEN-1:0]     o_pc,
  output logic                    o_commit,
  output logic                    o_halt
);

  logic                taken;
  logic [`RV_XLEN-1:0] pc_next;

  // branch condition from the rs1 vs rs2 compare
  always_comb begin
    case (i_dec.branch)
      rv_core_pkg::BR_EQ:  taken = i_flags.zero;
      rv_core_pkg::BR_NE:  taken = !i_flags.zero;
      rv_core_pkg::BR_LT:  taken = i_flags.lt_signed;
      rv_core_pkg::BR_GE:  taken = !i_flags.lt_signed;
      rv_core_pkg::BR_LTU: taken = i_flags.lt_unsigned;
      rv_core_pkg::BR_GEU: taken = !i_flags.lt_unsigned;
      default:             taken = 1'b0;
    endcase
  end

  assign pc_next  = taken ? (o_pc + i_dec.br_offset) : (o_pc + `RV_PC_STEP);
  assign o_commit = !o_halt;

  // the ecall itself still steps the pc, then everything freezes until reset
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_pc   <= `RV_RESET_PC;
      o_halt <= 1'b0;
    end else if (o_commit) begin
      o_pc   <= pc_next;
      o_halt <= i_dec.is_ecall;
    end
  end

  assert property (@(posedge clk) disable iff (rst) o_pc[1:0] == 2'b00);

  // once halted, pc and halt stay put
  assert property (@(posedge clk) disable iff (rst)
    o_halt |=> o_halt && $stable(o_pc));

endmodule

// ==== verilog/rv_core_top.sv ====
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module rv_core_top (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [`RV_XLEN-1:0]  i_insn,
  output logic [`RV_XLEN-1:0]  o_pc,
  output logic                 o_halt,
  output rv_core_pkg::retire_t o_retire
);

  rv_core_pkg::decoded_t   dec;
  rv_core_pkg::alu_flags_t flags;
  logic [`RV_XLEN-1:0]     rs1_data;
  logic [`RV_XLEN-1:0]     rs2_data;
  logic [`RV_XLEN-1:0]     alu_result;
  logic                    commit;

  rv_decode u_decode (
    .i_insn (i_insn),
    .o_dec  (dec)
  );

  // register file write data comes straight from the alu
  rv_regfile u_regfile (
    .clk        (clk),
    .rst        (rst),
    .i_dec      (dec),
    .i_commit   (commit),
    .i_wr_data  (alu_result),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data),
    .o_retire   (o_retire)
  );

  rv_alu u_alu (
    .i_dec      (dec),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .o_result   (alu_result),
    .o_flags    (flags)
  );

  rv_fetch u_fetch (
    .clk      (clk),
    .rst      (rst),
    .i_dec    (dec),
    .i_flags  (flags),
    .o_pc     (o_pc),
    .o_commit (commit),
    .o_halt   (o_halt)
  );

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter int HALF_PERIOD = 10,
  parameter int RST_CYCLES  = 8
) (
  output logic o_clk,
  output logic o_rst
);

  initial begin
    o_clk = 1'b0;
    forever #(HALF_PERIOD) o_clk = ~o_clk;
  end

  // release lands just after an edge, like the rest of the stimulus
  initial begin
    o_rst = 1'b1;
    repeat (RST_CYCLES) @(posedge o_clk);
    #2 o_rst = 1'b0;
  end

endmodule

// ==== tb/tb_rv_core.sv ====
`timescale 1ns/1ps
`include "rv_core_cfg.svh"

module tb_rv_core;

  localparam int MEM_WORDS  = 64;
  localparam int RST_CYCLES = 8;

  logic                 clk;
  logic                 rst;
  logic [`RV_XLEN-1:0]  i_insn;
  logic [`RV_XLEN-1:0]  dut_pc;
  logic                 dut_halt;
  rv_core_pkg::retire_t dut_retire;

  logic [31:0]          prog [MEM_WORDS];
  int                   prog_len;
  int                   fail_count;
  integer               seed;
  logic [31:0]          rnd;

  // reference model state
  logic [31:0]          m_regs [32];
  logic [31:0]          m_pc;
  logic                 m_halt;
  rv_core_pkg::retire_t exp_ret;

  tb_clock #(.HALF_PERIOD(10), .RST_CYCLES(RST_CYCLES)) u_clock (
    .o_clk (clk),
    .o_rst (rst)
  );

  rv_core_top DUT (
    .clk      (clk),
    .rst      (rst),
    .i_insn   (i_insn),
    .o_pc     (dut_pc),
    .o_halt   (dut_halt),
    .o_retire (dut_retire)
  );

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'h13};
  endfunction

  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'h37};
  endfunction

  task automatic emit(input logic [31:0] word);
    prog[prog_len] = word;
    prog_len++;
  endtask

  // executes one word by the ISA rules and returns next pc and write-back
  function automatic void ref_step(input logic [31:0] w, input logic [31:0] pc,
                                   input logic [31:0] a, input logic [31:0] rb,
                                   output logic [31:0] npc, output logic we,
                                   output logic [31:0] res, output logic halt);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] b;
    logic        cond;
    int          sh;
    opc  = w[6:0];
    f3   = w[14:12];
    f7   = w[31:25];
    npc  = pc + 32'd4;
    we   = 1'b0;
    res  = '0;
    halt = 1'b0;
    cond = 1'b0;
    b    = (opc == 7'h13) ? {{20{w[31]}}, w[31:20]} : rb;
    sh   = int'(b[4:0]);
    case (opc)
      7'h37: begin
        we  = 1'b1;
        res = {w[31:12], 12'b0};
      end
      7'h13, 7'h33: begin
        we = 1'b1;
        case (f3)
          3'd0: res = (opc == 7'h33 && f7[5]) ? a - b : a + b;
          3'd1: res = a << sh;
          3'd2: res = {31'b0, $signed(a) < $signed(b)};
          3'd3: res = {31'b0, a < b};
          3'd4: res = a ^ b;
          3'd5: begin
            if (f7[5]) begin
              res = $signed(a) >>> sh;
            end else begin
              res = a >> sh;
            end
          end
          3'd6: res = a | b;
          default: res = a & b;
        endcase
      end
      7'h63: begin
        case (f3)
          3'd0: cond = (a == rb);
          3'd1: cond = (a != rb);
          3'd4: cond = $signed(a) < $signed(rb);
          3'd5: cond = $signed(a) >= $signed(rb);
          3'd6: cond = a < rb;
          3'd7: cond = a >= rb;
          default: cond = 1'b0;
        endcase
        if (cond) begin
          npc = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      7'h73: halt = (w[31:7] == '0);
      default: ;
    endcase
  endfunction

  always @(posedge clk or posedge rst) begin : model
    logic [31:0] w;
    logic [31:0] npc;
    logic [31:0] res;
    logic        we;
    logic        halt;
    if (rst) begin
      m_pc    <= `RV_RESET_PC;
      m_halt  <= 1'b0;
      exp_ret <= '0;
      for (int i = 0; i < 32; i++) begin
        m_regs[i] <= '0;
      end
    end else if (!m_halt) begin
      w = prog[m_pc[7:2]];
      ref_step(w, m_pc, m_regs[w[19:15]], m_regs[w[24:20]], npc, we, res, halt);
      m_pc          <= npc;
      m_halt        <= halt;
      exp_ret.valid <= we && (w[11:7] != 5'd0);
      exp_ret.rd    <= w[11:7];
      exp_ret.data  <= res;
      if (we && (w[11:7] != 5'd0)) begin
        m_regs[w[11:7]] <= res;
      end
    end else begin
      exp_ret.valid <= 1'b0;
    end
  end

  // instruction port follows the word at the current pc
  always @(posedge clk) begin
    #2 i_insn = prog[dut_pc[7:2]];
  end

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    fail_count++;
    $display("Fail at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
    $display("Simulation failed");
    $fatal(1, "mismatch on %s", name);
  endtask

  a_reset_pc: assert property (@(posedge clk) rst |-> dut_pc == `RV_RESET_PC)
    else report_mismatch("o_pc", `RV_RESET_PC, $sampled(dut_pc));
  a_reset_flags: assert property (@(posedge clk) rst |-> !dut_halt && !dut_retire.valid)
    else report_mismatch("o_halt|o_retire.valid", 32'd0,
                         {30'b0, $sampled(dut_halt), $sampled(dut_retire.valid)});
  a_pc: assert property (@(posedge clk) disable iff (rst) dut_pc == m_pc)
    else report_mismatch("o_pc", $sampled(m_pc), $sampled(dut_pc));
  a_halt: assert property (@(posedge clk) disable iff (rst) dut_halt == m_halt)
    else report_mismatch("o_halt", {31'b0, $sampled(m_halt)}, {31'b0, $sampled(dut_halt)});
  a_valid: assert property (@(posedge clk) disable iff (rst)
    dut_retire.valid == exp_ret.valid)
    else report_mismatch("o_retire.valid", {31'b0, $sampled(exp_ret.valid)},
                         {31'b0, $sampled(dut_retire.valid)});
  a_rd: assert property (@(posedge clk) disable iff (rst)
    exp_ret.valid |-> dut_retire.rd == exp_ret.rd)
    else report_mismatch("o_retire.rd", {27'b0, $sampled(exp_ret.rd)},
                         {27'b0, $sampled(dut_retire.rd)});
  a_data: assert property (@(posedge clk) disable iff (rst)
    exp_ret.valid |-> dut_retire.data == exp_ret.data)
    else report_mismatch("o_retire.data", $sampled(exp_ret.data), $sampled(dut_retire.data));

  task automatic build_program();
    // unused words hold a custom-0 opcode tagged with their index
    for (int i = 0; i < MEM_WORDS; i++) begin
      prog[i] = {i[24:0], 7'h0b};
    end
    prog_len = 0;
    // x1 negative, x2 small positive, x3 small negative
    rnd = $random(seed);
    emit(enc_u({1'b1, rnd[18:0]}, 5'd1));
    rnd = $random(seed);
    emit(enc_i({1'b0, rnd[10:0] | 11'd1}, 5'd0, 3'd0, 5'd2));
    rnd = $random(seed);
    emit(enc_i({1'b1, rnd[10:0]}, 5'd0, 3'd0, 5'd3));
    rnd = $random(seed);
    emit(enc_i(rnd[11:0], 5'd1, 3'd0, 5'd4));
    emit(enc_i(rnd[23:12], 5'd3, 3'd2, 5'd5));
    rnd = $random(seed);
    emit(enc_i({1'b1, rnd[10:0]}, 5'd2, 3'd3, 5'd6));
    emit(enc_i(rnd[23:12], 5'd1, 3'd4, 5'd7));
    rnd = $random(seed);
    emit(enc_i(rnd[11:0], 5'd2, 3'd6, 5'd8));
    emit(enc_i(rnd[23:12], 5'd1, 3'd7, 5'd9));
    rnd = $random(seed);
    emit(enc_i({7'h00, rnd[4:0]}, 5'd2, 3'd1, 5'd10));
    emit(enc_i({7'h00, rnd[9:5]}, 5'd1, 3'd5, 5'd11));
    emit(enc_i({7'h20, rnd[14:10]}, 5'd1, 3'd5, 5'd12));
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd13));
    emit(enc_r(7'h20, 5'd1, 5'd2, 3'd0, 5'd14));
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'd1, 5'd15));
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd16));
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'd3, 5'd17));
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'd4, 5'd18));
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'd5, 5'd19));
    emit(enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd20));
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'd6, 5'd21));
    emit(enc_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd22));
    emit(enc_r(7'h00, 5'd1, 5'd2, 3'd2, 5'd23));
    emit(enc_r(7'h00, 5'd1, 5'd2, 3'd3, 5'd24));
    // write to x0, then read it back as a source
    rnd = $random(seed);
    emit(enc_i(rnd[11:0], 5'd2, 3'd0, 5'd0));
    emit(enc_r(7'h00, 5'd2, 5'd0, 3'd0, 5'd25));
    // each branch is taken and then not taken, and a taken one skips the filler
    emit_branch_pair(3'd0, 5'd1, 5'd1, 5'd1, 5'd2);
    emit_branch_pair(3'd1, 5'd1, 5'd2, 5'd2, 5'd2);
    emit_branch_pair(3'd4, 5'd1, 5'd2, 5'd2, 5'd1);
    emit_branch_pair(3'd5, 5'd2, 5'd1, 5'd1, 5'd2);
    emit_branch_pair(3'd6, 5'd2, 5'd1, 5'd1, 5'd2);
    emit_branch_pair(3'd7, 5'd1, 5'd2, 5'd2, 5'd1);
    // forward jump over a block, then a backward branch into it
    rnd = $random(seed);
    emit(enc_b(13'd12, 5'd0, 5'd0, 3'd0));
    emit(enc_i(rnd[11:0], 5'd28, 3'd0, 5'd28));
    emit(enc_b(13'd8, 5'd0, 5'd0, 3'd0));
    emit(enc_b(-13'sd8, 5'd1, 5'd2, 3'd6));
    emit(enc_i(12'd1, 5'd28, 3'd0, 5'd29));
    emit(32'h0000_0073);
  endtask

  task automatic emit_branch_pair(input logic [2:0] f3, input logic [4:0] t_rs1,
                                  input logic [4:0] t_rs2, input logic [4:0] n_rs1,
                                  input logic [4:0] n_rs2);
    emit(enc_b(13'd8, t_rs2, t_rs1, f3));
    emit(enc_i(12'd1, 5'd27, 3'd0, 5'd27));
    emit(enc_b(13'd8, n_rs2, n_rs1, f3));
    emit(enc_i(12'd1, 5'd27, 3'd0, 5'd27));
  endtask

  initial begin
    seed       = 90461;
    fail_count = 0;
    i_insn     = '0;
    build_program();
    wait (rst == 1'b0);
    while (!m_halt) begin
      @(posedge clk);
    end
    // halted core must stay frozen
    repeat (11) @(posedge clk);
    #1;
    if (fail_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // bound covers reset, every program word once and the halt check
  initial begin : watchdog
    int limit_ns;
    wait (prog_len != 0);
    limit_ns = (prog_len + 20 + RST_CYCLES) * 20;
    #(limit_ns);
    $display("timeout: the core did not reach ecall and finish within %0d ns", limit_ns);
    $display("Simulation failed");
    $fatal(1, "watchdog expired");
  end

endmodule

// ==== rv_core_top.f ====
+incdir+verilog
verilog/rv_core_pkg.sv
verilog/rv_decode.sv
verilog/rv_alu.sv
verilog/rv_regfile.sv
verilog/rv_fetch.sv
verilog/rv_core_top.sv
tb/tb_clock.sv
tb/tb_rv_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the rv_core_top testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_rv_core \
  -f rv_core_top.f -o tb_sim > sim.log 2>&1 \
  && ./obj_dir/tb_sim >> sim.log 2>&1 \
  || echo "Simulation failed" >> sim.log
grep -q "Simulation failed" sim.log \
  && { echo "FAIL (see sim.log)"; exit 1; } \
  || { echo "PASS"; exit 0; }
